//--- Makefile
# Verilator build and run for the out-of-order back end

SIM := obj_dir/Vooo_backend_tb
SRCS := $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): flist.f $(SRCS)
	verilator --binary --timing --top-module ooo_backend_tb \
		-f flist.f -o Vooo_backend_tb

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- bench/ooo_backend_tb.sv
// Dispatcher model stalls on full; the model drops all work younger than a taken beq
`timescale 1ns/10ps

`include "rob_cfg.svh"

module ooo_backend_tb;

  typedef struct {
    logic             v0;
    rob_pkg::alu_op_e op;
    logic [31:0]      a0;
    logic [31:0]      b0;
    logic [31:0]      imm;
    logic [31:0]      addr0;
    logic [4:0]       rd0;
    logic             v1;
    logic [31:0]      a1;
    logic [31:0]      b1;
    logic [31:0]      addr1;
    logic [4:0]       rd1;
    int               idle;
  } row_t;

  // One expected retirement
  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] result;
    logic [31:0] address;
    logic        jump;
    logic [31:0] jmp_address;
  } retire_t;

  logic clock = 1'b0;
  logic reset;
  logic issue0_valid;
  rob_pkg::alu_op_e issue0_op;
  logic [`XLEN-1:0] issue0_a;
  logic [`XLEN-1:0] issue0_b;
  logic [`XLEN-1:0] issue0_imm;
  logic [`XLEN-1:0] issue0_address;
  logic [4:0] issue0_rd;
  logic issue1_valid;
  logic [`XLEN-1:0] issue1_a;
  logic [`XLEN-1:0] issue1_b;
  logic [`XLEN-1:0] issue1_address;
  logic [4:0] issue1_rd;
  logic full;
  logic commit_valid;
  logic [4:0] commit_rd;
  logic [`XLEN-1:0] commit_result;
  logic [`XLEN-1:0] commit_address;
  logic jmp_write;
  logic [`XLEN-1:0] jmp_address;

  row_t    rows [64];
  int      n_rows = 0;
  retire_t retire_q [$];
  // Set from a taken beq until its jump is seen
  logic    drop_younger = 1'b0;
  logic    saw_full = 1'b0;
  logic [31:0] pc = 32'h0000_1000;
  int      rd_count = 0;
  int      cycles = 0;
  int      timeout_limit = 100000;
  // Cycles spent waiting for the last retirements
  int      drain = 0;
  integer  seed = 32'hda72dcce;

  ooo_backend u_ooo_backend (
    .clock         (clock),
    .reset         (reset),
    .issue0_valid  (issue0_valid),
    .issue0_op     (issue0_op),
    .issue0_a      (issue0_a),
    .issue0_b      (issue0_b),
    .issue0_imm    (issue0_imm),
    .issue0_address(issue0_address),
    .issue0_rd     (issue0_rd),
    .issue1_valid  (issue1_valid),
    .issue1_a      (issue1_a),
    .issue1_b      (issue1_b),
    .issue1_address(issue1_address),
    .issue1_rd     (issue1_rd),
    .full          (full),
    .commit_valid  (commit_valid),
    .commit_rd     (commit_rd),
    .commit_result (commit_result),
    .commit_address(commit_address),
    .jmp_write     (jmp_write),
    .jmp_address   (jmp_address)
  );

  // 100 ns period
  always #50 clock = ~clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] actual, input logic [31:0] want);
    if (actual !== want) begin
      fail_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, actual, want));
    end
  endtask

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > timeout_limit) begin
      fail_run("Timeout, the run took longer than the cycle limit");
    end
  end

  // Program addresses and destinations are handed out in order
  task automatic add_row(input logic v0, input rob_pkg::alu_op_e op,
                         input logic [31:0] a0, input logic [31:0] b0, input logic [31:0] imm,
                         input logic v1, input logic [31:0] a1, input logic [31:0] b1,
                         input int idle);
    row_t w;
    w.v0 = v0;
    w.op = op;
    w.a0 = a0;
    w.b0 = b0;
    w.imm = imm;
    w.addr0 = pc;
    w.rd0 = 5'(rd_count % 31 + 1);
    w.v1 = v1;
    w.a1 = a1;
    w.b1 = b1;
    w.addr1 = pc + 32'd4;
    w.rd1 = 5'((rd_count + 1) % 31 + 1);
    w.idle = idle;
    pc = pc + 32'd8;
    rd_count = rd_count + 2;
    rows[n_rows] = w;
    n_rows = n_rows + 1;
  endtask

  task automatic build_table();
    logic [31:0] r;
    logic [31:0] x;
    logic [31:0] y;
    rob_pkg::alu_op_e op;
    // Plain ALU rows, then pairs with a multiply
    add_row(1, rob_pkg::ALU_ADD, 32'd5, 32'd7, 0, 0, 0, 0, 3);
    add_row(1, rob_pkg::ALU_SUB, 32'd3, 32'd10, 0, 0, 0, 0, 0);
    add_row(1, rob_pkg::ALU_XOR, 32'hf0f0_1234, 32'h0ff0_4321, 0, 0, 0, 0, 2);
    add_row(1, rob_pkg::ALU_ADD, 32'hffff_ffff, 32'd2, 0, 1, 32'd12, 32'd13, 0);
    add_row(1, rob_pkg::ALU_SUB, 32'd100, 32'd1, 0, 1, 32'h0001_0000, 32'h0003_0000, 5);
    // Multiply overtaken by a later add
    add_row(0, rob_pkg::ALU_ADD, 0, 0, 0, 1, 32'd1234, 32'd5678, 0);
    add_row(1, rob_pkg::ALU_ADD, 32'd40, 32'd2, 0, 0, 0, 0, 0);
    add_row(1, rob_pkg::ALU_XOR, 32'd9, 32'd6, 0, 1, 32'hdead_beef, 32'd3, 6);
    // Not-taken beq, then a taken one with younger work in flight
    add_row(1, rob_pkg::ALU_BEQ, 32'd1, 32'd2, 32'h40, 0, 0, 0, 0);
    add_row(1, rob_pkg::ALU_ADD, 32'd8, 32'd8, 0, 0, 0, 0, 3);
    add_row(1, rob_pkg::ALU_BEQ, 32'd7, 32'd7, 32'h100, 1, 32'd3, 32'd4, 0);
    add_row(0, rob_pkg::ALU_ADD, 0, 0, 0, 1, 32'd21, 32'd2, 0);
    add_row(1, rob_pkg::ALU_SUB, 32'd9, 32'd1, 0, 1, 32'd5, 32'd5, 8);
    add_row(1, rob_pkg::ALU_ADD, 32'd77, 32'd1, 0, 0, 0, 0, 4);
    // Slow head, then a dual-issue burst to fill the buffer
    add_row(0, rob_pkg::ALU_ADD, 0, 0, 0, 1, 32'd11, 32'd11, 0);
    for (int i = 0; i < 16; i++) begin
      add_row(1, rob_pkg::ALU_ADD, 32'(i), 32'd100, 0, 1, 32'(i + 2), 32'd3, 0);
    end
    add_row(1, rob_pkg::ALU_XOR, 32'd1, 32'd3, 0, 0, 0, 0, 6);
    // Random mix with small beq operands so some are taken
    for (int i = 0; i < 24; i++) begin
      r = $random(seed);
      x = $random(seed);
      y = $random(seed);
      op = rob_pkg::alu_op_e'(r[2:1]);
      if (op == rob_pkg::ALU_BEQ) begin
        x = {31'd0, x[0]};
        y = {31'd0, y[0]};
      end
      add_row(r[0], op, x, y, {24'd0, r[15:10], 2'b00}, r[5], $random(seed), $random(seed),
              int'(r[4:3]));
    end
  endtask

  task automatic drive_idle();
    issue0_valid = 1'b0;
    issue1_valid = 1'b0;
  endtask

  // Drive one row and record what it should retire
  task automatic issue_row(input int idx);
    row_t    w;
    retire_t e;
    w = rows[idx];
    issue0_valid = w.v0;
    issue0_op = w.op;
    issue0_a = w.a0;
    issue0_b = w.b0;
    issue0_imm = w.imm;
    issue0_address = w.addr0;
    issue0_rd = w.rd0;
    issue1_valid = w.v1;
    issue1_a = w.a1;
    issue1_b = w.b1;
    issue1_address = w.addr1;
    issue1_rd = w.rd1;
    if (w.v0 && !drop_younger) begin
      e.rd = w.rd0;
      e.address = w.addr0;
      e.jump = 1'b0;
      e.jmp_address = w.addr0 + 32'd4;
      case (w.op)
        rob_pkg::ALU_ADD: e.result = w.a0 + w.b0;
        rob_pkg::ALU_SUB: e.result = w.a0 - w.b0;
        rob_pkg::ALU_XOR: e.result = w.a0 ^ w.b0;
        default: begin
          // Link value without write-back
          e.rd = 5'd0;
          e.result = w.addr0 + 32'd4;
          if (w.a0 == w.b0) begin
            e.jmp_address = w.addr0 + w.imm;
          end
          e.jump = (e.jmp_address != w.addr0 + 32'd4);
        end
      endcase
      retire_q.push_back(e);
      drop_younger = e.jump;
    end
    if (w.v1 && !drop_younger) begin
      e.rd = w.rd1;
      e.address = w.addr1;
      e.result = w.a1 * w.b1;
      e.jump = 1'b0;
      e.jmp_address = 32'd0;
      retire_q.push_back(e);
    end
  endtask

  // Outputs settled since the last rising edge
  task automatic step();
    retire_t e;
    @(negedge clock);
    if (jmp_write && !commit_valid) begin
      fail_run("Jump pulse seen without a retirement");
    end
    if (commit_valid) begin
      if (retire_q.size() == 0) begin
        fail_run("Retirement seen when no instruction was expected");
      end else begin
        e = retire_q.pop_front();
        check("commit_address", commit_address, e.address);
        check("commit_rd", 32'(commit_rd), 32'(e.rd));
        check("commit_result", commit_result, e.result);
        check("jmp_write", 32'(jmp_write), 32'(e.jump));
        if (e.jump) begin
          check("jmp_address", jmp_address, e.jmp_address);
          drop_younger = 1'b0;
        end
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    issue0_op = rob_pkg::ALU_ADD;
    issue0_a = '0;
    issue0_b = '0;
    issue0_imm = '0;
    issue0_address = '0;
    issue0_rd = '0;
    issue1_a = '0;
    issue1_b = '0;
    issue1_address = '0;
    issue1_rd = '0;
    drive_idle();
    build_table();
    timeout_limit = 40 * n_rows + 100;
    repeat (2) @(negedge clock);
    reset = 1'b0;
    // Quiet after reset
    step();
    check("commit_valid", 32'(commit_valid), 32'd0);
    check("jmp_write", 32'(jmp_write), 32'd0);
    check("full", 32'(full), 32'd0);
    for (int r = 0; r < n_rows; r++) begin
      step();
      // Dispatcher stalls on full
      while (full) begin
        saw_full = 1'b1;
        drive_idle();
        step();
      end
      issue_row(r);
      for (int i = 0; i < rows[r].idle; i++) begin
        step();
        drive_idle();
      end
    end
    step();
    drive_idle();
    // A full buffer drains within its depth plus one multiply
    while (retire_q.size() != 0 && drain < 2 * `ROB_SIZE + `MUL_STAGES) begin
      step();
      drain = drain + 1;
    end
    // Catch stray retirements
    repeat (8) step();
    check("full raised during burst", 32'(saw_full), 32'd1);
    check("full", 32'(full), 32'd0);
    if (retire_q.size() != 0) begin
      fail_run("Instructions were left unretired at the end of the run");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

//--- flist.f
+incdir+hw
hw/rob_pkg.sv
hw/alu_lane.sv
hw/mul_lane.sv
hw/reorder_buffer.sv
hw/ooo_backend.sv
bench/ooo_backend_tb.sv

//--- hw/alu_lane.sv
// One-cycle ALU lane for slot 0; a flush kills both the bus output and any issue in that cycle
`timescale 1ns/10ps

`include "rob_cfg.svh"

module alu_lane (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  issue_valid,
  input  rob_pkg::alu_op_e      op,
  input  logic [`XLEN-1:0]      a,
  input  logic [`XLEN-1:0]      b,
  input  logic [`XLEN-1:0]      imm,
  input  logic [`XLEN-1:0]      address,
  input  rob_pkg::rob_tag_t     tag,
  output logic                  cdb_valid,
  output rob_pkg::rob_tag_t     cdb_tag,
  output logic [`XLEN-1:0]      cdb_result,
  output logic [`XLEN-1:0]      cdb_jmp_address
);

  logic [`XLEN-1:0] fall_through;
  logic [`XLEN-1:0] result_d;
  logic [`XLEN-1:0] jmp_d;

  // Next sequential address, also the beq link value
  assign fall_through = address + 'd4;

  always_comb begin
    result_d = a + b;
    // Non-branches report fall-through, never used by the buffer
    jmp_d    = fall_through;
    case (op)
      rob_pkg::ALU_ADD: result_d = a + b;
      rob_pkg::ALU_SUB: result_d = a - b;
      rob_pkg::ALU_XOR: result_d = a ^ b;
      rob_pkg::ALU_BEQ: begin
        // Link value, not written back
        result_d = fall_through;
        if (a == b) begin
          jmp_d = address + imm;
        end
      end
      default: result_d = a + b;
    endcase
  end

  // Bus strobe
  // Issue in a flush cycle is dropped here
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= issue_valid;
    end
  end

  // Bus payload, held between issues
  always_ff @(posedge clock) begin
    if (issue_valid) begin
      cdb_tag         <= tag;
      cdb_result      <= result_d;
      cdb_jmp_address <= jmp_d;
    end
  end

endmodule

//--- hw/mul_lane.sv
// Multiply lane for slot 1; keeps only the low XLEN bits and accepts one issue per cycle
`timescale 1ns/10ps

`include "rob_cfg.svh"

module mul_lane (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  issue_valid,
  input  logic [`XLEN-1:0]      a,
  input  logic [`XLEN-1:0]      b,
  input  rob_pkg::rob_tag_t     tag,
  output logic                  cdb_valid,
  output rob_pkg::rob_tag_t     cdb_tag,
  output logic [`XLEN-1:0]      cdb_result
);

  // One valid bit per stage
  logic [`MUL_STAGES-1:0] stage_valid;
  rob_pkg::rob_tag_t      stage_tag  [`MUL_STAGES];
  logic [`XLEN-1:0]       stage_prod [`MUL_STAGES];
  logic [`XLEN-1:0]       product;

  // Low half of the product only
  assign product = a * b;

  // Valid chain
  // Flush empties every stage at once
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      stage_valid <= '0;
    end else begin
      stage_valid[0] <= issue_valid;
      for (int i = 1; i < `MUL_STAGES; i++) begin
        stage_valid[i] <= stage_valid[i-1];
      end
    end
  end

  // Tag and product ride alongside the valid
  always_ff @(posedge clock) begin
    stage_tag[0]  <= tag;
    stage_prod[0] <= product;
    for (int i = 1; i < `MUL_STAGES; i++) begin
      stage_tag[i]  <= stage_tag[i-1];
      stage_prod[i] <= stage_prod[i-1];
    end
  end

  // Last stage drives bus 1
  assign cdb_valid  = stage_valid[`MUL_STAGES-1];
  assign cdb_tag    = stage_tag[`MUL_STAGES-1];
  assign cdb_result = stage_prod[`MUL_STAGES-1];

endmodule

//--- hw/ooo_backend.sv
// Dual-issue back end top; slot 0 is ALU only, slot 1 multiply only, issue must stop while full is high
`timescale 1ns/10ps

`include "rob_cfg.svh"

module ooo_backend (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  issue0_valid,
  input  rob_pkg::alu_op_e      issue0_op,
  input  logic [`XLEN-1:0]      issue0_a,
  input  logic [`XLEN-1:0]      issue0_b,
  input  logic [`XLEN-1:0]      issue0_imm,
  input  logic [`XLEN-1:0]      issue0_address,
  input  logic [4:0]            issue0_rd,
  input  logic                  issue1_valid,
  input  logic [`XLEN-1:0]      issue1_a,
  input  logic [`XLEN-1:0]      issue1_b,
  input  logic [`XLEN-1:0]      issue1_address,
  input  logic [4:0]            issue1_rd,
  output logic                  full,
  output logic                  commit_valid,
  output logic [4:0]            commit_rd,
  output logic [`XLEN-1:0]      commit_result,
  output logic [`XLEN-1:0]      commit_address,
  output logic                  jmp_write,
  output logic [`XLEN-1:0]      jmp_address
);

  // Tags from buffer to lanes
  rob_pkg::rob_tag_t alloc_tag0;
  rob_pkg::rob_tag_t alloc_tag1;
  logic              flush;

  // Completion bus 0, ALU lane
  logic              cdb0_valid;
  rob_pkg::rob_tag_t cdb0_tag;
  logic [`XLEN-1:0]  cdb0_result;
  logic [`XLEN-1:0]  cdb0_jmp_address;

  // Completion bus 1, multiply lane
  logic              cdb1_valid;
  rob_pkg::rob_tag_t cdb1_tag;
  logic [`XLEN-1:0]  cdb1_result;

  alu_lane u_alu_lane (
    .clock          (clock),
    .reset          (reset),
    .flush          (flush),
    .issue_valid    (issue0_valid),
    .op             (issue0_op),
    .a              (issue0_a),
    .b              (issue0_b),
    .imm            (issue0_imm),
    .address        (issue0_address),
    .tag            (alloc_tag0),
    .cdb_valid      (cdb0_valid),
    .cdb_tag        (cdb0_tag),
    .cdb_result     (cdb0_result),
    .cdb_jmp_address(cdb0_jmp_address)
  );

  mul_lane u_mul_lane (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .issue_valid(issue1_valid),
    .a          (issue1_a),
    .b          (issue1_b),
    .tag        (alloc_tag1),
    .cdb_valid  (cdb1_valid),
    .cdb_tag    (cdb1_tag),
    .cdb_result (cdb1_result)
  );

  reorder_buffer u_reorder_buffer (
    .clock           (clock),
    .reset           (reset),
    .issue0_valid    (issue0_valid),
    .issue0_op       (issue0_op),
    .issue0_address  (issue0_address),
    .issue0_rd       (issue0_rd),
    .issue1_valid    (issue1_valid),
    .issue1_address  (issue1_address),
    .issue1_rd       (issue1_rd),
    .cdb0_valid      (cdb0_valid),
    .cdb0_tag        (cdb0_tag),
    .cdb0_result     (cdb0_result),
    .cdb0_jmp_address(cdb0_jmp_address),
    .cdb1_valid      (cdb1_valid),
    .cdb1_tag        (cdb1_tag),
    .cdb1_result     (cdb1_result),
    .alloc_tag0      (alloc_tag0),
    .alloc_tag1      (alloc_tag1),
    .flush           (flush),
    .full            (full),
    .commit_valid    (commit_valid),
    .commit_rd       (commit_rd),
    .commit_result   (commit_result),
    .commit_address  (commit_address),
    .jmp_write       (jmp_write),
    .jmp_address     (jmp_address)
  );

endmodule

//--- hw/reorder_buffer.sv
// In-order retire, one per cycle; dispatcher must stall on full, and a mispredict drops all younger work
`timescale 1ns/10ps

`include "rob_cfg.svh"

module reorder_buffer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  issue0_valid,
  input  rob_pkg::alu_op_e      issue0_op,
  input  logic [`XLEN-1:0]      issue0_address,
  input  logic [4:0]            issue0_rd,
  input  logic                  issue1_valid,
  input  logic [`XLEN-1:0]      issue1_address,
  input  logic [4:0]            issue1_rd,
  input  logic                  cdb0_valid,
  input  rob_pkg::rob_tag_t     cdb0_tag,
  input  logic [`XLEN-1:0]      cdb0_result,
  input  logic [`XLEN-1:0]      cdb0_jmp_address,
  input  logic                  cdb1_valid,
  input  rob_pkg::rob_tag_t     cdb1_tag,
  input  logic [`XLEN-1:0]      cdb1_result,
  output rob_pkg::rob_tag_t     alloc_tag0,
  output rob_pkg::rob_tag_t     alloc_tag1,
  output logic                  flush,
  output logic                  full,
  output logic                  commit_valid,
  output logic [4:0]            commit_rd,
  output logic [`XLEN-1:0]      commit_result,
  output logic [`XLEN-1:0]      commit_address,
  output logic                  jmp_write,
  output logic [`XLEN-1:0]      jmp_address
);

  typedef enum logic [1:0] {
    ST_FREE,
    ST_WAITING,
    ST_COMPLETED
  } entry_status_e;

  typedef struct packed {
    logic             is_branch;
    logic [4:0]       rd;
    logic [`XLEN-1:0] address;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] jmp_address;
  } rob_entry_t;

  // Holds 0 to ROB_SIZE
  typedef logic [`ROB_TAG_W:0] count_t;

  entry_status_e     status  [`ROB_SIZE];
  rob_entry_t        entries [`ROB_SIZE];

  rob_pkg::rob_tag_t rd_idx;
  rob_pkg::rob_tag_t wr_idx;
  rob_pkg::rob_tag_t wr_next;
  rob_pkg::rob_tag_t head_next;
  count_t            count;
  count_t            count_next;

  rob_entry_t        head;
  logic [`XLEN-1:0]  head_fall;
  logic              retire;
  logic              mispredict;
  logic              alloc0;
  logic              alloc1;
  logic              cdb0_hit;
  logic              cdb1_hit;

  assign head      = entries[rd_idx];
  assign head_fall = head.address + 'd4;
  assign head_next = rob_pkg::rob_tag_t'(rd_idx + 1);

  // Head done, retire it now
  assign retire     = (status[rd_idx] == ST_COMPLETED);
  // Not-taken prediction wrong when target leaves fall-through
  assign mispredict = retire && head.is_branch && (head.jmp_address != head_fall);
  assign flush      = mispredict;

  // Slot 0 is older, so it takes the lower index
  assign alloc_tag0 = wr_idx;
  assign alloc_tag1 = issue0_valid ? rob_pkg::rob_tag_t'(wr_idx + 1) : wr_idx;

  // Issues in a flush cycle are dropped
  assign alloc0 = issue0_valid && !mispredict;
  assign alloc1 = issue1_valid && !mispredict;

  // Completions for freed entries are ignored
  assign cdb0_hit = cdb0_valid && (status[cdb0_tag] == ST_WAITING);
  assign cdb1_hit = cdb1_valid && (status[cdb1_tag] == ST_WAITING);

  // Fewer than two free entries
  assign full = (count > count_t'(`ROB_SIZE - 2));

  always_comb begin
    wr_next    = wr_idx;
    count_next = count;
    if (alloc0) begin
      wr_next    = rob_pkg::rob_tag_t'(wr_next + 1);
      count_next = count_t'(count_next + 1);
    end
    if (alloc1) begin
      wr_next    = rob_pkg::rob_tag_t'(wr_next + 1);
      count_next = count_t'(count_next + 1);
    end
    if (retire) begin
      count_next = count_t'(count_next - 1);
    end
  end

  // Status and indices
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `ROB_SIZE; i++) begin
        status[i] <= ST_FREE;
      end
      rd_idx <= '0;
      wr_idx <= '0;
      count  <= '0;
    end else if (mispredict) begin
      // Only the branch itself is older, and it retires now
      for (int i = 0; i < `ROB_SIZE; i++) begin
        status[i] <= ST_FREE;
      end
      rd_idx <= head_next;
      wr_idx <= head_next;
      count  <= '0;
    end else begin
      if (cdb0_hit) begin
        status[cdb0_tag] <= ST_COMPLETED;
      end
      if (cdb1_hit) begin
        status[cdb1_tag] <= ST_COMPLETED;
      end
      if (retire) begin
        status[rd_idx] <= ST_FREE;
        rd_idx         <= head_next;
      end
      // Never collides with the head while full is honored
      if (alloc0) begin
        status[alloc_tag0] <= ST_WAITING;
      end
      if (alloc1) begin
        status[alloc_tag1] <= ST_WAITING;
      end
      wr_idx <= wr_next;
      count  <= count_next;
    end
  end

  // Entry payload
  always_ff @(posedge clock) begin
    if (alloc0) begin
      entries[alloc_tag0].is_branch <= (issue0_op == rob_pkg::ALU_BEQ);
      entries[alloc_tag0].rd        <= issue0_rd;
      entries[alloc_tag0].address   <= issue0_address;
    end
    if (alloc1) begin
      // Multiplies never branch
      entries[alloc_tag1].is_branch <= 1'b0;
      entries[alloc_tag1].rd        <= issue1_rd;
      entries[alloc_tag1].address   <= issue1_address;
    end
    if (cdb0_hit) begin
      entries[cdb0_tag].result      <= cdb0_result;
      entries[cdb0_tag].jmp_address <= cdb0_jmp_address;
    end
    if (cdb1_hit) begin
      entries[cdb1_tag].result <= cdb1_result;
    end
  end

  // Retirement strobes
  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      jmp_write    <= 1'b0;
    end else begin
      commit_valid <= retire;
      jmp_write    <= mispredict;
    end
  end

  // Retirement payload
  // Branches report rd zero, link value is not written
  always_ff @(posedge clock) begin
    if (retire) begin
      commit_rd      <= head.is_branch ? 5'd0 : head.rd;
      commit_result  <= head.result;
      commit_address <= head.address;
      jmp_address    <= head.jmp_address;
    end
  end

endmodule

//--- hw/rob_cfg.svh
// Sizes shared by all back end blocks; ROB_SIZE must equal 2**ROB_TAG_W so that indices wrap
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// Reorder buffer entries
// Power of two, indices wrap naturally
`define ROB_SIZE 16

// Width of an entry index
`define ROB_TAG_W 4

// Data and address width
`define XLEN 32

// Multiply pipeline depth
// One register per stage, first stage captured at issue
`define MUL_STAGES 3

`endif

//--- hw/rob_pkg.sv
// Types shared by the lanes and the reorder buffer; tag width follows ROB_TAG_W in rob_cfg.svh

`include "rob_cfg.svh"

package rob_pkg;

  // Slot-0 operation
  // Two bits, one ALU lane decodes all four
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    // Compare and branch, predicted not taken
    ALU_BEQ
  } alu_op_e;

  // Reorder buffer entry index
  // Also the tag carried by each lane down to its completion bus
  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

endpackage
